/* rtl/intToDoublePkg.sv */
`default_nettype none

package intToDoublePkg;

  // the double format fixes these widths.
  localparam int ExpWidth = 11;
  localparam int MantWidth = 52;

  localparam logic [ExpWidth-1:0] ExpBias = 11'd1023;

  // word addresses of the CPU-visible registers.
  typedef enum logic [2:0] {
    OPLO   = 3'd0,
    OPHI   = 3'd1,
    CTRL   = 3'd2,
    STATUS = 3'd3,
    RESLO  = 3'd4,
    RESHI  = 3'd5,
    RESEXP = 3'd6
  } regIdxE;

  // a double seen either as two bus words or as its IEEE 754 fields.
  typedef union packed {
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } raw;
    struct packed {
      logic                 sign;
      logic [ExpWidth-1:0]  exponent;
      logic [MantWidth-1:0] mantissa;
    } fields;
  } doubleU;

endpackage

`default_nettype wire

/* rtl/msbOneHot.sv */
`timescale 1ns/1ns
`default_nettype none

module msbOneHot (
  input  logic [63:0] in,
  output logic [63:0] out
);

  // later iterations overwrite earlier ones, so the highest set bit wins.
  always_comb begin
    out = '0;
    for (int i = 0; i < 64; i++) begin
      if (in[i]) begin
        out = 64'd1 << i;
      end
    end
  end

  // the detector must never report two leading ones, nor miss a nonzero input.
  oneHotChk: assert final ($onehot0(out) && ((out == '0) == (in == '0)))
    else $error("msbOneHot produced %h for input %h", out, in);

endmodule

`default_nettype wire

/* rtl/doubleNormalizer.sv */
`timescale 1ns/1ns
`default_nettype none

module doubleNormalizer (
  input  logic        clk,
  input  logic        rstN,
  input  logic        launch,
  input  logic [63:0] operand,
  input  logic        signedMode,
  output logic        normValid,
  output logic        normSign,
  output logic        normZero,
  output logic [10:0] normExp,
  output logic [63:0] normFrac,
  output logic        stageBusy
);

  logic        s1Valid;
  logic        s1Sign;
  logic [63:0] s1Mag;
  logic        opNeg;
  logic [63:0] oneHot;
  logic [5:0]  msbIdx;
  logic [intToDoublePkg::ExpWidth-1:0] expNext;
  logic [63:0] fracNext;

  // the most negative operand negates to 2^63, which still fits unsigned.
  assign opNeg = signedMode & operand[63];

  msbOneHot leadOne (
    .in  (s1Mag),
    .out (oneHot)
  );

  always_comb begin
    msbIdx = '0;
    for (int i = 0; i < 64; i++) begin
      if (oneHot[i]) begin
        msbIdx = msbIdx | 6'(i);
      end
    end
  end

  assign expNext = intToDoublePkg::ExpBias + {5'd0, msbIdx};
  // left-justify so the leading one lands on bit 63.
  assign fracNext = s1Mag << (6'd63 - msbIdx);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s1Valid   <= 1'b0;
      s1Sign    <= 1'b0;
      s1Mag     <= '0;
      normValid <= 1'b0;
      normSign  <= 1'b0;
      normZero  <= 1'b0;
      normExp   <= '0;
      normFrac  <= '0;
    end else begin
      s1Valid   <= launch;
      normValid <= s1Valid;
      if (launch) begin
        s1Sign <= opNeg;
        s1Mag  <= opNeg ? -operand : operand;
      end
      if (s1Valid) begin
        normSign <= s1Sign;
        normZero <= ~|oneHot;
        normExp  <= expNext;
        normFrac <= fracNext;
      end
    end
  end

  assign stageBusy = s1Valid | normValid;

  normJustified: assert property (@(posedge clk) disable iff (!rstN)
    (normValid && !normZero) |-> normFrac[63])
    else $error("normalized fraction %h has no leading one", normFrac);

endmodule

`default_nettype wire

/* rtl/doubleRounder.sv */
`timescale 1ns/1ns
`default_nettype none

module doubleRounder (
  input  logic        clk,
  input  logic        rstN,
  input  logic        normValid,
  input  logic        normSign,
  input  logic        normZero,
  input  logic [10:0] normExp,
  input  logic [63:0] normFrac,
  output logic        resValid,
  output logic [63:0] result,
  output logic        rndBusy
);

  logic [intToDoublePkg::MantWidth-1:0] mant;
  logic                                 guard;
  logic                                 sticky;
  logic                                 roundUp;
  logic [intToDoublePkg::MantWidth:0]   mantSum;
  intToDoublePkg::doubleU               resNext;
  intToDoublePkg::doubleU               resReg;

  // bit 63 is the hidden one and is dropped.
  assign mant    = normFrac[62:11];
  assign guard   = normFrac[10];
  assign sticky  = |normFrac[9:0];
  assign roundUp = guard & (sticky | mant[0]);
  assign mantSum = {1'b0, mant} + {{intToDoublePkg::MantWidth{1'b0}}, roundUp};

  always_comb begin
    resNext = '0;
    if (!normZero) begin
      resNext.fields.sign     = normSign;
      // an overflowing mantissa wraps to zero and bumps the exponent.
      resNext.fields.exponent = normExp
                                + {10'd0, mantSum[intToDoublePkg::MantWidth]};
      resNext.fields.mantissa = mantSum[intToDoublePkg::MantWidth-1:0];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resValid <= 1'b0;
      resReg   <= '0;
    end else begin
      resValid <= normValid;
      if (normValid) begin
        resReg <= resNext;
      end
    end
  end

  assign result  = resReg;
  assign rndBusy = resValid;

  // a 64-bit integer rounds to at most 2^64.
  expBound: assert property (@(posedge clk) disable iff (!rstN)
    resValid |-> resReg.fields.exponent <= intToDoublePkg::ExpBias + 11'd64)
    else $error("result exponent %0d out of range", resReg.fields.exponent);

endmodule

`default_nettype wire

/* rtl/wbConvRegs.sv */
`timescale 1ns/1ns
`default_nettype none

module wbConvRegs (
  input  logic        clk,
  input  logic        rstN,
  input  logic        wbCyc,
  input  logic        wbStb,
  input  logic        wbWe,
  input  logic [2:0]  wbAdr,
  input  logic [3:0]  wbSel,
  input  logic [31:0] wbDatW,
  output logic [31:0] wbDatR,
  output logic        wbAck,
  output logic        launch,
  output logic [63:0] operand,
  output logic        signedMode,
  input  logic        resValid,
  input  logic [63:0] result,
  input  logic        stageBusy,
  input  logic        rndBusy
);

  logic [31:0]            opLo;
  logic [31:0]            opHi;
  logic [31:0]            hiMerged;
  logic                   accept;
  logic                   wrEn;
  logic                   rdResHi;
  logic                   busy;
  logic                   resultValid;
  logic [31:0]            readMux;
  intToDoublePkg::doubleU resReg;

  function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                             input logic [31:0] data,
                                             input logic [3:0]  sel);
    logic [31:0] merged;
    merged = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // a request is taken once; the cycle holding ack is not a new request.
  assign accept  = wbCyc & wbStb & ~wbAck;
  assign wrEn    = accept & wbWe;
  assign rdResHi = accept & ~wbWe & (wbAdr == intToDoublePkg::RESHI);

  // the high word is merged here so the launching edge sees the new operand.
  assign hiMerged = mergeBytes(opHi, wbDatW, wbSel);
  assign launch   = wrEn & (wbAdr == intToDoublePkg::OPHI);
  assign operand  = {launch ? hiMerged : opHi, opLo};

  assign busy = stageBusy | rndBusy;

  always_comb begin
    readMux = '0;
    case (wbAdr)
      intToDoublePkg::OPLO:   readMux = opLo;
      intToDoublePkg::OPHI:   readMux = opHi;
      intToDoublePkg::CTRL:   readMux = {31'd0, signedMode};
      intToDoublePkg::STATUS: readMux = {30'd0, resultValid, busy};
      intToDoublePkg::RESLO:  readMux = resReg.raw.lo;
      intToDoublePkg::RESHI:  readMux = resReg.raw.hi;
      intToDoublePkg::RESEXP: readMux = {resReg.fields.sign, 20'd0, resReg.fields.exponent};
      default:                readMux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbAck       <= 1'b0;
      wbDatR      <= '0;
      opLo        <= '0;
      opHi        <= '0;
      signedMode  <= 1'b0;
      resultValid <= 1'b0;
      resReg      <= '0;
    end else begin
      wbAck  <= accept;
      wbDatR <= (accept && !wbWe) ? readMux : '0;

      if (wrEn) begin
        case (wbAdr)
          intToDoublePkg::OPLO: opLo <= mergeBytes(opLo, wbDatW, wbSel);
          intToDoublePkg::OPHI: opHi <= hiMerged;
          intToDoublePkg::CTRL: begin
            if (wbSel[0]) begin
              signedMode <= wbDatW[0];
            end
          end
          default: ;
        endcase
      end

      if (resValid) begin
        resReg <= result;
      end

      // a completion on the same edge as the RESHI read keeps the flag set.
      if (resValid) begin
        resultValid <= 1'b1;
      end else if (rdResHi) begin
        resultValid <= 1'b0;
      end
    end
  end

  ackSingle: assert property (@(posedge clk) disable iff (!rstN)
    wbAck |=> !wbAck)
    else $error("wbAck held for two cycles");

endmodule

`default_nettype wire

/* rtl/intToDouble.sv */
`timescale 1ns/1ns
`default_nettype none

module intToDouble (
  input  logic        clk,
  input  logic        rstN,
  input  logic        wbCyc,
  input  logic        wbStb,
  input  logic        wbWe,
  input  logic [2:0]  wbAdr,
  input  logic [3:0]  wbSel,
  input  logic [31:0] wbDatW,
  output logic [31:0] wbDatR,
  output logic        wbAck
);

  logic        launch;
  logic [63:0] operand;
  logic        signedMode;
  logic        normValid;
  logic        normSign;
  logic        normZero;
  logic [10:0] normExp;
  logic [63:0] normFrac;
  logic        stageBusy;
  logic        resValid;
  logic [63:0] result;
  logic        rndBusy;

  wbConvRegs convRegs (
    .clk        (clk),
    .rstN       (rstN),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAdr      (wbAdr),
    .wbSel      (wbSel),
    .wbDatW     (wbDatW),
    .wbDatR     (wbDatR),
    .wbAck      (wbAck),
    .launch     (launch),
    .operand    (operand),
    .signedMode (signedMode),
    .resValid   (resValid),
    .result     (result),
    .stageBusy  (stageBusy),
    .rndBusy    (rndBusy)
  );

  doubleNormalizer normalizer (
    .clk        (clk),
    .rstN       (rstN),
    .launch     (launch),
    .operand    (operand),
    .signedMode (signedMode),
    .normValid  (normValid),
    .normSign   (normSign),
    .normZero   (normZero),
    .normExp    (normExp),
    .normFrac   (normFrac),
    .stageBusy  (stageBusy)
  );

  doubleRounder rounder (
    .clk       (clk),
    .rstN      (rstN),
    .normValid (normValid),
    .normSign  (normSign),
    .normZero  (normZero),
    .normExp   (normExp),
    .normFrac  (normFrac),
    .resValid  (resValid),
    .result    (result),
    .rndBusy   (rndBusy)
  );

endmodule

`default_nettype wire

/* test/intToDoubleChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module intToDoubleChecker (
  input  logic        clk,
  input  logic        rstN,
  input  logic        wbCyc,
  input  logic        wbStb,
  input  logic        wbWe,
  input  logic [2:0]  wbAdr,
  input  logic [3:0]  wbSel,
  input  logic [31:0] wbDatW,
  input  logic [31:0] wbDatR,
  input  logic        wbAck,
  input  logic [63:0] tableResult,
  input  logic        tableValid,
  output int          errCount
);

  logic [31:0]            opLo;
  logic [31:0]            opHi;
  logic                   signedMode;
  logic                   pending;
  logic                   ackSeen;
  intToDoublePkg::doubleU expected;

  function automatic logic [31:0] applySel(input logic [31:0] old,
                                           input logic [31:0] data,
                                           input logic [3:0]  sel);
    logic [31:0] word;
    word = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    return word;
  endfunction

  // round to nearest even on the integer itself, then pack the fields.
  function automatic logic [63:0] convertModel(input logic [63:0] value, input logic isSigned);
    intToDoublePkg::doubleU res;
    logic        neg;
    logic [63:0] mag;
    logic [63:0] kept;
    logic [63:0] rest;
    logic [63:0] half;
    int          lead;
    int          shift;
    res = '0;
    neg = isSigned && value[63];
    mag = neg ? (~value + 64'd1) : value;
    if (mag == 64'd0) begin
      return res;
    end
    lead = 63;
    while (!mag[lead]) begin
      lead--;
    end
    if (lead <= 52) begin
      kept = mag << (52 - lead);
    end else begin
      shift = lead - 52;
      kept  = mag >> shift;
      rest  = mag & ((64'd1 << shift) - 64'd1);
      half  = 64'd1 << (shift - 1);
      if (rest > half || (rest == half && kept[0])) begin
        kept = kept + 64'd1;
      end
      if (kept[53]) begin
        kept = kept >> 1;
        lead++;
      end
    end
    res.fields.sign     = neg;
    res.fields.exponent = intToDoublePkg::ExpBias + 11'(lead);
    res.fields.mantissa = kept[51:0];
    return res;
  endfunction

  task automatic compareWord(input string name, input logic [31:0] want,
                             input logic [31:0] got);
    if (want !== got) begin
      $display("Fail time=%0t %s expected=%h actual=%h", $time, name, want, got);
      errCount++;
    end
  endtask

  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      opLo       = '0;
      opHi       = '0;
      signedMode = 1'b0;
      pending    = 1'b0;
      ackSeen    = 1'b0;
      expected   = '0;
      errCount   = 0;
    end else begin
      if (wbAck && (ackSeen || !(wbCyc && wbStb))) begin
        $display("time %0t: wbAck was not a single pulse inside a bus cycle", $time);
        errCount++;
      end
      ackSeen = wbAck;
      if (wbAck && wbWe) begin
        case (wbAdr)
          intToDoublePkg::OPLO: opLo = applySel(opLo, wbDatW, wbSel);
          intToDoublePkg::CTRL: signedMode = wbSel[0] ? wbDatW[0] : signedMode;
          intToDoublePkg::OPHI: begin
            opHi     = applySel(opHi, wbDatW, wbSel);
            expected = convertModel({opHi, opLo}, signedMode);
            pending  = 1'b1;
            if (tableValid && expected !== tableResult) begin
              $display("model gives %h for operand %h but the table says %h",
                       expected, {opHi, opLo}, tableResult);
              errCount++;
            end
          end
          default: ;
        endcase
      end else if (wbAck) begin
        case (wbAdr)
          intToDoublePkg::STATUS: begin
            // until the result is valid the conversion is still in flight, so busy reads set.
            if (!pending) begin
              compareWord("STATUS", 32'd0, wbDatR);
            end else if (wbDatR[1]) begin
              compareWord("STATUS", 32'd2, wbDatR);
              pending = 1'b0;
            end else begin
              compareWord("STATUS", 32'd1, wbDatR);
            end
          end
          intToDoublePkg::RESLO: compareWord("RESLO", expected.raw.lo, wbDatR);
          intToDoublePkg::RESHI: compareWord("RESHI", expected.raw.hi, wbDatR);
          intToDoublePkg::RESEXP: compareWord("RESEXP",
              {expected.fields.sign, 20'd0, expected.fields.exponent}, wbDatR);
          intToDoublePkg::CTRL: compareWord("CTRL", {31'd0, signedMode}, wbDatR);
          intToDoublePkg::OPLO: compareWord("OPLO", opLo, wbDatR);
          intToDoublePkg::OPHI: compareWord("OPHI", opHi, wbDatR);
          default: compareWord("unused word", 32'd0, wbDatR);
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* test/intToDoubleTb.sv */
`timescale 1ns/1ns
`default_nettype none

module intToDoubleTb;

  localparam int AckTimeout  = 20;
  localparam int PollTimeout = 30;
  localparam int NumDirected = 9;
  localparam int NumRandom   = 40;

  logic         clk;
  logic         rstN;
  logic         wbCyc;
  logic         wbStb;
  logic         wbWe;
  logic [2:0]   wbAdr;
  logic [3:0]   wbSel;
  logic [31:0]  wbDatW;
  logic [31:0]  wbDatR;
  logic         wbAck;
  logic [63:0]  tableResult;
  logic         tableValid;
  int           checkErrors;
  int           tbErrors;
  logic [31:0]  rngState;
  logic [31:0]  drawHi;
  logic [31:0]  drawLo;
  logic [31:0]  readData;
  logic [128:0] entry;

  intToDouble dut (
    .clk    (clk),
    .rstN   (rstN),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbSel  (wbSel),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck)
  );

  intToDoubleChecker busCheck (
    .clk         (clk),
    .rstN        (rstN),
    .wbCyc       (wbCyc),
    .wbStb       (wbStb),
    .wbWe        (wbWe),
    .wbAdr       (wbAdr),
    .wbSel       (wbSel),
    .wbDatW      (wbDatW),
    .wbDatR      (wbDatR),
    .wbAck       (wbAck),
    .tableResult (tableResult),
    .tableValid  (tableValid),
    .errCount    (checkErrors)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // each entry is {signedMode, operand, expected double}.
  function automatic logic [128:0] directedEntry(input int n);
    case (n)
      0: return {1'b0, 64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000};
      1: return {1'b0, 64'h0000_0000_0000_0001, 64'h3ff0_0000_0000_0000};
      2: return {1'b0, 64'h0000_0100_0000_0000, 64'h4270_0000_0000_0000};
      3: return {1'b0, 64'h8000_0000_0000_0000, 64'h43e0_0000_0000_0000};
      4: return {1'b1, 64'hffff_ffff_ffff_ffff, 64'hbff0_0000_0000_0000};
      5: return {1'b1, 64'h8000_0000_0000_0000, 64'hc3e0_0000_0000_0000};
      6: return {1'b0, 64'h0020_0000_0000_0001, 64'h4340_0000_0000_0000};
      7: return {1'b0, 64'h0020_0000_0000_0003, 64'h4340_0000_0000_0002};
      8: return {1'b0, 64'hffff_ffff_ffff_ffff, 64'h43f0_0000_0000_0000};
      default: return '0;
    endcase
  endfunction

  task automatic busAccess(input logic write, input logic [2:0] adr,
                           input logic [31:0] data, output logic [31:0] rdata);
    int waitCycles;
    waitCycles = 0;
    @(posedge clk);
    wbCyc  <= 1'b1;
    wbStb  <= 1'b1;
    wbWe   <= write;
    wbAdr  <= adr;
    wbSel  <= 4'hf;
    wbDatW <= write ? data : 32'd0;
    @(posedge clk);
    while (!wbAck && waitCycles < AckTimeout) begin
      @(posedge clk);
      waitCycles++;
    end
    if (!wbAck) begin
      $display("time %0t: no acknowledge for word %0d within %0d cycles",
               $time, adr, AckTimeout);
      tbErrors++;
    end
    rdata = wbDatR;
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
  endtask

  task automatic busWrite(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] ignored;
    busAccess(1'b1, adr, data, ignored);
  endtask

  task automatic busRead(input logic [2:0] adr, output logic [31:0] data);
    busAccess(1'b0, adr, 32'd0, data);
  endtask

  task automatic waitResult;
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < PollTimeout) begin
      busRead(intToDoublePkg::STATUS, status);
      polls++;
    end
    if (!status[1]) begin
      $display("time %0t: result never became valid after %0d polls", $time, PollTimeout);
      tbErrors++;
    end
  endtask

  task automatic runConversion(input logic [63:0] op, input logic mode,
                               input logic [63:0] want, input logic wantValid);
    logic [31:0] rdata;
    @(posedge clk);
    tableResult <= want;
    tableValid  <= wantValid;
    busWrite(intToDoublePkg::CTRL, {31'd0, mode});
    busWrite(intToDoublePkg::OPLO, op[31:0]);
    busWrite(intToDoublePkg::OPHI, op[63:32]);
    waitResult();
    busRead(intToDoublePkg::RESEXP, rdata);
    busRead(intToDoublePkg::RESLO, rdata);
    busRead(intToDoublePkg::RESHI, rdata);
    // reading RESHI clears resultValid, so STATUS is back to zero.
    busRead(intToDoublePkg::STATUS, rdata);
  endtask

  initial begin
    clk         = 1'b0;
    rstN        = 1'b0;
    wbCyc       = 1'b0;
    wbStb       = 1'b0;
    wbWe        = 1'b0;
    wbAdr       = '0;
    wbSel       = '0;
    wbDatW      = '0;
    tableResult = '0;
    tableValid  = 1'b0;
    tbErrors    = 0;
    rngState    = 32'h23c0_6768;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;

    busRead(intToDoublePkg::STATUS, readData);
    busRead(3'd7, readData);

    for (int i = 0; i < NumDirected; i++) begin
      entry = directedEntry(i);
      runConversion(entry[127:64], entry[128], entry[63:0], 1'b1);
    end

    for (int i = 0; i < NumRandom; i++) begin
      rngState = nextRandom(rngState);
      drawHi   = rngState;
      rngState = nextRandom(rngState);
      drawLo   = rngState;
      runConversion({drawHi, drawLo}, drawLo[15], 64'd0, 1'b0);
    end

    repeat (2) @(posedge clk);
    $display("checker errors: %0d, testbench errors: %0d", checkErrors, tbErrors);
    if (checkErrors == 0 && tbErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* intToDouble.f */
rtl/intToDoublePkg.sv
rtl/msbOneHot.sv
rtl/doubleNormalizer.sv
rtl/doubleRounder.sv
rtl/wbConvRegs.sv
rtl/intToDouble.sv
test/intToDoubleChecker.sv
test/intToDoubleTb.sv

/* Bender.yml */
package:
  name: intToDouble

sources:
  - rtl/intToDoublePkg.sv
  - rtl/msbOneHot.sv
  - rtl/doubleNormalizer.sv
  - rtl/doubleRounder.sv
  - rtl/wbConvRegs.sv
  - rtl/intToDouble.sv
  - target: test
    files:
      - test/intToDoubleChecker.sv
      - test/intToDoubleTb.sv
